//--- xge_stream_pkg.sv
//////////////////////////////////////////////////
// Stream widths and lane count of the 10G port
// Wide host beat and narrow MAC-side beat structs
//////////////////////////////////////////////////

`default_nettype none

package xge_stream_pkg;

  // Data path widths
  localparam int wide_data_w    = 256;                      // Host side
  localparam int narrow_data_w  = 64;                       // MAC side
  localparam int tuser_w        = 128;                      // Sideband, same on both sides
  localparam int lanes_per_beat = wide_data_w / narrow_data_w;

  // Derived widths
  localparam int wide_keep_w    = wide_data_w / 8;          // One bit per byte
  localparam int narrow_keep_w  = narrow_data_w / 8;
  localparam int lane_idx_w     = $clog2(lanes_per_beat);

  //////////////////////////////////////////////////
  // Beat structs
  //////////////////////////////////////////////////

  // One host beat, 417 bits
  typedef struct packed {
    logic [wide_data_w-1:0] tdata;
    logic [wide_keep_w-1:0] tkeep;                          // Contiguous from byte 0
    logic [tuser_w-1:0]     tuser;
    logic                   tlast;
  } axis_wide_t;

  // One MAC-side beat, 201 bits
  typedef struct packed {
    logic [narrow_data_w-1:0] tdata;
    logic [narrow_keep_w-1:0] tkeep;
    logic [tuser_w-1:0]       tuser;                        // Copied from the wide beat
    logic                     tlast;
  } axis_narrow_t;

endpackage

`default_nettype wire

//--- xge_regs_pkg.sv
//////////////////////////////////////////////////
// Register map of the port wrapper
// Default values, interface number, strobe bus structs
//////////////////////////////////////////////////

`default_nettype none

package xge_regs_pkg;

  localparam int reg_addr_w = 8;
  localparam int reg_data_w = 32;

  // Byte addresses
  localparam logic [reg_addr_w-1:0] addr_id          = 8'h00;
  localparam logic [reg_addr_w-1:0] addr_version     = 8'h04;
  localparam logic [reg_addr_w-1:0] addr_flip        = 8'h08;
  localparam logic [reg_addr_w-1:0] addr_counter_in  = 8'h0C;
  localparam logic [reg_addr_w-1:0] addr_counter_out = 8'h10;
  localparam logic [reg_addr_w-1:0] addr_debug       = 8'h14;

  // Fixed values
  localparam logic [15:0]           if_number          = 16'h0003;      // Upper half of ID
  localparam logic [15:0]           id_default_low     = 16'hDA01;
  localparam logic [reg_data_w-1:0] version_default    = 32'h0001_0200;
  localparam logic [reg_data_w-1:0] flip_default       = 32'h0000_0000;
  localparam logic [reg_data_w-1:0] debug_default      = 32'h0000_1000; // Added on write
  localparam logic [reg_data_w-1:0] reg_unmapped_value = 32'hDEAD_BEEF;

  //////////////////////////////////////////////////
  // Register strobe bus
  //////////////////////////////////////////////////

  // Request, wr and rd never together
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [reg_addr_w-1:0] addr;
    logic [reg_data_w-1:0] wdata;
  } reg_req_t;

  // Response, one cycle after rd
  typedef struct packed {
    logic                  rd_valid;
    logic [reg_data_w-1:0] rdata;
  } reg_rsp_t;

endpackage

`default_nettype wire

//--- axis_width_narrow.sv
//////////////////////////////////////////////////
// 256 to 64 bit stream converter, host to MAC
// Emits the live lanes of each wide beat in order
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axis_width_narrow
  import xge_stream_pkg::*;
(
  input  logic         axi_aclk,
  input  logic         resetn_sync,
  // Host side
  input  axis_wide_t   tx_s_beat,
  input  logic         tx_s_valid,
  output logic         tx_s_ready,
  // MAC side
  output axis_narrow_t tx_m_beat,
  output logic         tx_m_valid,
  input  logic         tx_m_ready,
  // Packet pulse to counters
  output logic         tx_pkt_accepted
);

  axis_wide_t            hold_buf;    // Accepted wide beat
  logic                  hold_valid;  // Buffer owns a beat
  logic [lane_idx_w-1:0] lane_idx;    // Lane now on tx_m
  logic [lane_idx_w-1:0] lane_nxt;
  logic                  last_lane;   // Current lane is the final live one
  logic                  s_take;
  logic                  m_take;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign lane_nxt = lane_idx + 1'b1;

  // Top lane, or next keep group empty
  assign last_lane = (lane_idx == lane_idx_w'(lanes_per_beat - 1)) ||
                     (hold_buf.tkeep[lane_nxt*narrow_keep_w +: narrow_keep_w] == '0);

  assign m_take     = hold_valid && tx_m_ready;
  assign tx_s_ready = !hold_valid || (last_lane && tx_m_ready);  // Empty or draining
  assign s_take     = tx_s_valid && tx_s_ready;
  assign tx_m_valid = hold_valid;

  // Lane select
  always_comb begin
    tx_m_beat.tdata = hold_buf.tdata[lane_idx*narrow_data_w +: narrow_data_w];
    tx_m_beat.tkeep = hold_buf.tkeep[lane_idx*narrow_keep_w +: narrow_keep_w];
    tx_m_beat.tuser = hold_buf.tuser;                      // Same tuser on every lane
    tx_m_beat.tlast = hold_buf.tlast && last_lane;         // Only on the final lane
  end

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////

  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      hold_valid      <= 1'b0;
      lane_idx        <= '0;
      tx_pkt_accepted <= 1'b0;
    end else begin
      tx_pkt_accepted <= s_take && tx_s_beat.tlast;       // End of packet taken
      if (s_take) begin
        hold_valid <= 1'b1;
        lane_idx   <= '0;                                 // Lane 0 out next cycle
      end else if (m_take) begin
        if (last_lane)
          hold_valid <= 1'b0;
        else
          lane_idx <= lane_nxt;
      end
    end
  end

  // Payload, loaded on acceptance only
  always_ff @(posedge axi_aclk) begin
    if (s_take)
      hold_buf <= tx_s_beat;
  end

endmodule

`default_nettype wire

//--- axis_width_widen.sv
//////////////////////////////////////////////////
// 64 to 256 bit stream converter, MAC to host
// Packs narrow beats four per wide beat
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axis_width_widen
  import xge_stream_pkg::*;
(
  input  logic         axi_aclk,
  input  logic         resetn_sync,
  // MAC side
  input  axis_narrow_t rx_s_beat,
  input  logic         rx_s_valid,
  output logic         rx_s_ready,
  // Host side
  output axis_wide_t   rx_m_beat,
  output logic         rx_m_valid,
  input  logic         rx_m_ready,
  // Packet pulse to counters
  output logic         rx_pkt_delivered
);

  axis_wide_t            acc_buf;     // Lanes gathered so far
  axis_wide_t            merged;      // acc_buf plus the incoming lane
  axis_wide_t            out_buf;     // Completed wide beat
  logic                  out_valid;
  logic [lane_idx_w-1:0] fill_idx;    // Next lane to fill
  logic                  s_take;
  logic                  m_take;
  logic                  close_beat;  // Wide beat completes this cycle

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign rx_s_ready = !(out_valid && !rx_m_ready);        // Stall while full beat waits
  assign s_take     = rx_s_valid && rx_s_ready;
  assign m_take     = out_valid && rx_m_ready;
  assign close_beat = s_take &&
                      ((fill_idx == lane_idx_w'(lanes_per_beat - 1)) || rx_s_beat.tlast);

  assign rx_m_beat  = out_buf;
  assign rx_m_valid = out_valid;

  // Drop the incoming beat into its lane
  always_comb begin
    merged = acc_buf;
    merged.tdata[fill_idx*narrow_data_w +: narrow_data_w] = rx_s_beat.tdata;
    merged.tkeep[fill_idx*narrow_keep_w +: narrow_keep_w] = rx_s_beat.tkeep;
    if (fill_idx == '0)
      merged.tuser = rx_s_beat.tuser;                     // First beat owns tuser
    merged.tlast = rx_s_beat.tlast;
  end

  //////////////////////////////////////////////////
  // Accumulator and output state
  //////////////////////////////////////////////////

  // Accumulator is cleared so unfilled lanes read as zero
  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      acc_buf          <= '0;
      fill_idx         <= '0;
      out_valid        <= 1'b0;
      rx_pkt_delivered <= 1'b0;
    end else begin
      rx_pkt_delivered <= m_take && out_buf.tlast;
      if (close_beat) begin
        acc_buf  <= '0;
        fill_idx <= '0;
      end else if (s_take) begin
        acc_buf  <= merged;
        fill_idx <= fill_idx + 1'b1;
      end
      if (close_beat)
        out_valid <= 1'b1;                                // Replaces a beat taken now
      else if (m_take)
        out_valid <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (close_beat)
      out_buf <= merged;                                  // Held until rx_m_ready
  end

endmodule

`default_nettype wire

//--- if_reg_ctrl.sv
//////////////////////////////////////////////////
// Register block of the port wrapper
// Write decode, flip and debug registers,
// packet counters with sticky overflow, read mux
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module if_reg_ctrl
  import xge_regs_pkg::*;
(
  input  logic     axi_aclk,
  input  logic     resetn_sync,
  // Register strobe bus
  input  reg_req_t reg_req,
  output reg_rsp_t reg_rsp,
  // Packet pulses from the converters
  input  logic     tx_pkt_accepted,
  input  logic     rx_pkt_delivered
);

  logic [reg_data_w-1:0] flip_reg;
  logic [reg_data_w-1:0] debug_reg;
  logic [reg_data_w-1:0] counter_in;     // Host packets accepted
  logic [reg_data_w-1:0] counter_out;    // Host packets delivered
  logic [reg_data_w-1:0] rd_mux;

  logic wr_flip;
  logic wr_debug;
  logic clr_in;
  logic clr_out;

  //////////////////////////////////////////////////
  // Counter step
  //////////////////////////////////////////////////

  // Bits 30..0 count, bit 31 sticks on wrap
  function automatic logic [reg_data_w-1:0] count_step(
    input logic [reg_data_w-1:0] cnt,
    input logic                  clr,
    input logic                  inc
  );
    logic [reg_data_w-1:0] nxt;
    nxt = cnt;
    if (clr) begin
      nxt = '0;                                           // Clear wins over a pulse
    end else if (inc) begin
      nxt[reg_data_w-2:0] = cnt[reg_data_w-2:0] + 1'b1;
      nxt[reg_data_w-1]   = cnt[reg_data_w-1] | (&cnt[reg_data_w-2:0]);
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  assign wr_flip  = reg_req.wr && (reg_req.addr == addr_flip);
  assign wr_debug = reg_req.wr && (reg_req.addr == addr_debug);
  assign clr_in   = reg_req.wr && (reg_req.addr == addr_counter_in);   // Clear on write
  assign clr_out  = reg_req.wr && (reg_req.addr == addr_counter_out);

  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      flip_reg    <= flip_default;
      debug_reg   <= debug_default;
      counter_in  <= '0;
      counter_out <= '0;
    end else begin
      if (wr_flip)
        flip_reg <= ~reg_req.wdata;                       // Store the inverse
      if (wr_debug)
        debug_reg <= reg_req.wdata + debug_default;
      counter_in  <= count_step(counter_in, clr_in, tx_pkt_accepted);
      counter_out <= count_step(counter_out, clr_out, rx_pkt_delivered);
    end
  end

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  always_comb begin
    case (reg_req.addr)
      addr_id:          rd_mux = {if_number, id_default_low};
      addr_version:     rd_mux = version_default;
      addr_flip:        rd_mux = flip_reg;
      addr_counter_in:  rd_mux = counter_in;
      addr_counter_out: rd_mux = counter_out;
      addr_debug:       rd_mux = debug_reg;
      default:          rd_mux = reg_unmapped_value;      // Outside the map
    endcase
  end

  // Response one cycle after rd
  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync)
      reg_rsp.rd_valid <= 1'b0;
    else
      reg_rsp.rd_valid <= reg_req.rd;
  end

  always_ff @(posedge axi_aclk) begin
    if (reg_req.rd)
      reg_rsp.rdata <= rd_mux;                            // Held between reads
  end

endmodule

`default_nettype wire

//--- xge_if_top.sv
//////////////////////////////////////////////////
// Top level of the 10G port packet path
// Transmit narrowing, receive widening, registers
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module xge_if_top
  import xge_stream_pkg::*, xge_regs_pkg::*;
(
  input  logic         axi_aclk,
  input  logic         resetn_sync,
  // Host transmit stream, 256 bit
  input  axis_wide_t   tx_s_beat,
  input  logic         tx_s_valid,
  output logic         tx_s_ready,
  // MAC transmit stream, 64 bit
  output axis_narrow_t tx_m_beat,
  output logic         tx_m_valid,
  input  logic         tx_m_ready,
  // MAC receive stream, 64 bit
  input  axis_narrow_t rx_s_beat,
  input  logic         rx_s_valid,
  output logic         rx_s_ready,
  // Host receive stream, 256 bit
  output axis_wide_t   rx_m_beat,
  output logic         rx_m_valid,
  input  logic         rx_m_ready,
  // Register strobe bus
  input  reg_req_t     reg_req,
  output reg_rsp_t     reg_rsp
);

  logic tx_pkt_accepted;   // Last wide beat taken from host
  logic rx_pkt_delivered;  // Last wide beat handed to host

  //////////////////////////////////////////////////
  // Packet path
  //////////////////////////////////////////////////

  axis_width_narrow u_tx_narrow (
    .axi_aclk        (axi_aclk),
    .resetn_sync     (resetn_sync),
    .tx_s_beat       (tx_s_beat),
    .tx_s_valid      (tx_s_valid),
    .tx_s_ready      (tx_s_ready),
    .tx_m_beat       (tx_m_beat),
    .tx_m_valid      (tx_m_valid),
    .tx_m_ready      (tx_m_ready),
    .tx_pkt_accepted (tx_pkt_accepted)
  );

  axis_width_widen u_rx_widen (
    .axi_aclk         (axi_aclk),
    .resetn_sync      (resetn_sync),
    .rx_s_beat        (rx_s_beat),
    .rx_s_valid       (rx_s_valid),
    .rx_s_ready       (rx_s_ready),
    .rx_m_beat        (rx_m_beat),
    .rx_m_valid       (rx_m_valid),
    .rx_m_ready       (rx_m_ready),
    .rx_pkt_delivered (rx_pkt_delivered)
  );

  // Registers, counting both directions
  if_reg_ctrl u_reg_ctrl (
    .axi_aclk         (axi_aclk),
    .resetn_sync      (resetn_sync),
    .reg_req          (reg_req),
    .reg_rsp          (reg_rsp),
    .tx_pkt_accepted  (tx_pkt_accepted),
    .rx_pkt_delivered (rx_pkt_delivered)
  );

endmodule

`default_nettype wire

//--- tb_xge_if.sv
//////////////////////////////////////////////////
// Testbench of the 10G port packet path
// Stim file commands, reference queues for both
// streams, random back-pressure, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_xge_if
  import xge_stream_pkg::*, xge_regs_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int cycles_per_line = 40;     // Watchdog budget per stim line

  logic         axi_aclk;
  logic         resetn_sync;
  axis_wide_t   tx_s_beat;
  logic         tx_s_valid;
  logic         tx_s_ready;
  axis_narrow_t tx_m_beat;
  logic         tx_m_valid;
  logic         tx_m_ready = 1'b0;
  axis_narrow_t rx_s_beat;
  logic         rx_s_valid;
  logic         rx_s_ready;
  axis_wide_t   rx_m_beat;
  logic         rx_m_valid;
  logic         rx_m_ready = 1'b0;
  reg_req_t     reg_req;
  reg_rsp_t     reg_rsp;

  axis_narrow_t tx_exp[$];                 // Expected MAC-side beats
  axis_wide_t   rx_exp[$];                 // Expected host-side beats
  axis_wide_t   rx_acc;                    // Model lane fill
  int           rx_fill    = 0;
  axis_narrow_t tx_held;
  axis_wide_t   rx_held;
  logic         tx_stalled = 1'b0;
  logic         rx_stalled = 1'b0;
  int           seed       = 32'h0c57_dca8;
  int           bp_seed    = 32'h0c57_dca8;
  int           line_count = 0;
  int           checks     = 0;
  int           errors     = 0;

  xge_if_top DUT (.*);

  always #(clk_period/2) axi_aclk = ~axi_aclk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input logic [511:0] got, input logic [511:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Contiguous keep from byte 0
  function automatic logic [31:0] keep_mask(input int bytes);
    logic [31:0] m;
    for (int i = 0; i < 32; i++)
      m[i] = (i < bytes);
    return m;
  endfunction

  // Sends one wide beat and queues its live lanes as narrow beats
  task automatic send_wide(input logic [31:0] mix, input int bytes, input logic last);
    axis_wide_t   b;
    axis_narrow_t n;
    int           live;
    for (int w = 0; w < 8; w++)
      b.tdata[32*w +: 32] = $random(seed) ^ mix;
    for (int w = 0; w < 4; w++)
      b.tuser[32*w +: 32] = $random(seed);
    b.tkeep = keep_mask(bytes);
    b.tlast = last;
    live    = (bytes + 7) / 8;               // Lanes with a nonzero keep group
    for (int k = 0; k < live; k++) begin
      n.tdata = b.tdata[64*k +: 64];
      n.tkeep = b.tkeep[8*k +: 8];
      n.tuser = b.tuser;
      n.tlast = last && (k == live - 1);     // Final live lane only
      tx_exp.push_back(n);
    end
    tx_s_beat  = b;
    tx_s_valid = 1'b1;
    @(negedge axi_aclk);
    while (!tx_s_ready)
      @(negedge axi_aclk);
    @(posedge axi_aclk);                     // Accepted on this edge
    #1;
    tx_s_valid = 1'b0;
  endtask

  // Sends one narrow beat while the model packs lanes 0 to 3
  task automatic send_narrow(input logic [31:0] low, input int bytes, input logic last);
    axis_narrow_t n;
    logic [31:0]  m;
    m       = keep_mask(bytes);
    n.tdata = {$random(seed), low};
    n.tkeep = m[7:0];
    for (int w = 0; w < 4; w++)
      n.tuser[32*w +: 32] = $random(seed);
    n.tlast = last;
    if (rx_fill == 0) begin
      rx_acc       = '0;                     // Unfilled lanes stay zero
      rx_acc.tuser = n.tuser;
    end
    rx_acc.tdata[64*rx_fill +: 64] = n.tdata;
    rx_acc.tkeep[8*rx_fill +: 8]   = n.tkeep;
    if (rx_fill == 3 || last) begin
      rx_acc.tlast = last;
      rx_exp.push_back(rx_acc);
      rx_fill = 0;
    end else begin
      rx_fill++;
    end
    rx_s_beat  = n;
    rx_s_valid = 1'b1;
    @(negedge axi_aclk);
    while (!rx_s_ready)
      @(negedge axi_aclk);
    @(posedge axi_aclk);
    #1;
    rx_s_valid = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(posedge axi_aclk);
    #1;
    reg_req.wr = 1'b0;
  endtask

  // Response due one cycle after the strobe
  task automatic reg_read(input logic [7:0] addr, input logic [31:0] expected);
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    @(posedge axi_aclk);
    #1;
    reg_req.rd = 1'b0;
    @(negedge axi_aclk);
    check(512'({reg_rsp.rd_valid, reg_rsp.rdata}), 512'({1'b1, expected}), "register read");
    @(posedge axi_aclk);
    #1;
  endtask

  // Both streams empty, then counters settle
  task automatic drain();
    while (tx_exp.size() != 0 || rx_exp.size() != 0)
      @(posedge axi_aclk);
    repeat (2) @(posedge axi_aclk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Back-pressure and output monitors
  //////////////////////////////////////////////////

  always @(posedge axi_aclk) begin
    #1;
    tx_m_ready = ($random(bp_seed) & 3) != 0;  // Low about one cycle in four
    rx_m_ready = ($random(bp_seed) & 3) != 0;
  end

  always @(negedge axi_aclk) begin
    if (resetn_sync) begin
      if (tx_stalled)
        check(512'({tx_m_valid, tx_m_beat}), 512'({1'b1, tx_held}), "tx_m beat held");
      if (tx_m_valid && !tx_m_ready)
        check(512'(tx_s_ready), 512'(1'b0), "tx_s_ready while a lane is stalled");
      tx_stalled = tx_m_valid && !tx_m_ready;
      tx_held    = tx_m_beat;
      if (tx_m_valid && tx_m_ready) begin
        if (tx_exp.size() == 0) begin
          errors++;
          $display("Transmit beat at %0t ns arrived with no beat expected", $time);
        end else begin
          check(512'(tx_m_beat), 512'(tx_exp.pop_front()), "tx_m beat");
        end
      end
    end
  end

  always @(negedge axi_aclk) begin
    if (resetn_sync) begin
      if (rx_stalled)
        check(512'({rx_m_valid, rx_m_beat}), 512'({1'b1, rx_held}), "rx_m beat held");
      if (rx_m_valid && !rx_m_ready)
        check(512'(rx_s_ready), 512'(1'b0), "rx_s_ready while a wide beat waits");
      rx_stalled = rx_m_valid && !rx_m_ready;
      rx_held    = rx_m_beat;
      if (rx_m_valid && rx_m_ready) begin
        if (rx_exp.size() == 0) begin
          errors++;
          $display("Receive beat at %0t ns arrived with no beat expected", $time);
        end else begin
          check(512'(rx_m_beat), 512'(rx_exp.pop_front()), "rx_m beat");
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    int          fd;
    int          r;
    string       line;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic        done;
    axi_aclk    = 1'b0;
    resetn_sync = 1'b0;
    tx_s_beat   = '0;
    tx_s_valid  = 1'b0;
    rx_s_beat   = '0;
    rx_s_valid  = 1'b0;
    reg_req     = '0;
    fd = $fopen("xge_if_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file xge_if_stim.txt");
    end else begin
      while ($fgets(line, fd) != 0)
        line_count++;                        // Sets the watchdog budget
      $fclose(fd);
      fd = $fopen("xge_if_stim.txt", "r");
      repeat (4) @(posedge axi_aclk);
      #1;
      resetn_sync = 1'b1;
      @(negedge axi_aclk);
      check(512'({tx_s_ready, tx_m_valid, rx_m_valid, reg_rsp.rd_valid}), 512'(4'b1000),
            "outputs after reset");
      @(posedge axi_aclk);
      #1;
      done = 1'b0;
      while (!done) begin
        r = $fscanf(fd, "%s", cmd);
        if (r != 1) begin
          done = 1'b1;
        end else if (cmd == "#") begin
          r = $fgets(line, fd);              // Skip column notes
        end else begin
          r = $fscanf(fd, "%h %h %h", a, b, c);
          case (cmd)
            "W": begin
              drain();
              reg_write(a[7:0], b);
            end
            "R": begin
              drain();
              reg_read(a[7:0], b);
            end
            "T": send_wide(a, int'(b), c[0]);
            "X": send_narrow(a, int'(b), c[0]);
            default: begin
              errors++;
              $display("Unknown command in the stimulus file");
            end
          endcase
        end
      end
      drain();
      $fclose(fd);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // Budget counted from reset release, once all stim lines are known
  initial begin
    wait (resetn_sync === 1'b1);
    #(longint'(line_count) * cycles_per_line * clk_period);
    $display("Timeout: the run did not finish within %0d cycles",
             line_count * cycles_per_line);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
xge_stream_pkg.sv
xge_regs_pkg.sv
axis_width_narrow.sv
axis_width_widen.sv
if_reg_ctrl.sv
xge_if_top.sv
tb_xge_if.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_xge_if -o tb_xge_if \
  && ./obj_dir/tb_xge_if | tee /dev/stderr | grep -qx "Test passed" \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }

//--- xge_if_stim.txt
# Columns, hex: cmd a b c | W addr data 0 | R addr expected 0
# T seed_mix byte_count last (256 bit beat) | X data_low byte_count last (64 bit beat)
R 00 0003da01 0
R 04 00010200 0
R 3c deadbeef 0
R 08 00000000 0
W 08 12345678 0
R 08 edcba987 0
R 14 00001000 0
W 14 00000025 0
R 14 00001025 0
T 1111 20 0
T 1112 20 1
T 2221 0d 1
T 3331 20 0
T 3332 11 1
T 4441 08 1
T 5551 20 1
X a001 8 0
X a002 8 0
X a003 8 0
X a004 8 0
X a005 3 1
X b001 8 0
X b002 6 1
X c001 8 0
X c002 8 0
X c003 8 0
X c004 5 1
X d001 8 1
R 0c 00000005 0
R 10 00000004 0
W 0c 0 0
R 0c 0 0
W 10 0 0
R 10 0 0
